// ==== divPkg.sv ====
/*
  Shared definitions for the radix-2 SRT significand divider
  Widths of significand, quotient, residual and step counter
  Vector types passed between the divider blocks
*/
package divPkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Significand width, leading one included, so a value lies in [1,2)
  localparam int DivLen = 16;

  // One digit per cycle, the first digit carries the integer weight
  // so a quotient in (0.5,2) needs one digit more than the significand
  localparam int NumDigits = DivLen + 1;

  // The step counter has to reach NumDigits
  localparam int DurLen = 5;

  ////////////////////////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////////////////////////

  // Normalized significand with bit 15 set
  typedef logic [DivLen-1:0] sigT;

  // Truncated quotient, also the width of its on-the-fly partner Q-1
  typedef logic [NumDigits-1:0] quotT;

  // One carry-save word of the partial remainder
  // Bit 19 is the sign, bits 18..16 hold integer growth
  // Bits 15..0 are the fraction, so X/2 fits below the point and the
  // doubled residual never leaves the range of four integer bits
  typedef logic [DivLen+3:0] residualT;

  // Step count, and at done the number of skipped trailing digits
  typedef logic [DurLen-1:0] durT;

endpackage

// ==== residualIf.sv ====
/*
  Carry-save residual bundle between the SRT iteration datapath
  and the divider controller, with a driving and a reading view
*/
`timescale 1ns/1ps

interface residualIf;
  import divPkg::*;

  // Registered sum and carry words of the partial remainder
  residualT wS;
  residualT wC;

  // Words the datapath will register on the next iterate edge
  residualT nextWS;
  residualT nextWC;

  // The datapath owns the residual registers and the adder tree
  modport datapath (
    output wS,
    output wC,
    output nextWS,
    output nextWC
  );

  // The controller only looks at the words for zero, sign and sticky
  modport control (
    input wS,
    input wC,
    input nextWS,
    input nextWC
  );

endinterface

// ==== srtController.sv ====
/*
  Divider control FSM with idle, busy and done states
  Step counter, early termination on a zero residual
  Sticky and remainder sign from the registered residual
*/
`timescale 1ns/1ps

module srtController (
  input  logic clk,
  input  logic reset,
  input  logic start,
  input  logic holdStart,
  input  logic holdResult,
  input  logic xZero,
  input  logic yZero,
  input  logic xInf,
  input  logic yInf,
  input  logic xNaN,
  input  logic yNaN,
  residualIf.control res,
  output logic load,
  output logic iterate,
  output divPkg::durT earlyShift,
  output logic negRemainder,
  output logic sticky,
  output logic busy,
  output logic done
);
  import divPkg::*;

  typedef enum logic [1:0] {StIdle, StBusy, StDone} stateT;

  stateT state;
  durT step;
  logic accept;
  logic special;
  logic lastStep;
  logic nextZero;
  residualT remainder;

  // A start only counts while idle and while the execute stage is not held
  assign accept = start & ~holdStart & (state == StIdle);
  assign special = xZero | yZero | xInf | yInf | xNaN | yNaN;
  assign lastStep = (step == durT'(1));

  // Zero test of the next residual straight on the carry-save pair
  // The two words sum to zero exactly when their XOR equals their OR moved up one bit
  assign nextZero = ((res.nextWS ^ res.nextWC) ==
                     {res.nextWS[DivLen+2:0] | res.nextWC[DivLen+2:0], 1'b0});

  ////////////////////////////////////////////////////////////
  // State and step counter
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= StIdle;
      step  <= '0;
    end else begin
      case (state)
        StIdle: begin
          if (accept) begin
            step <= durT'(NumDigits);
            // Special operands need no digits, the later stage builds the result
            state <= special ? StDone : StBusy;
          end
        end
        StBusy: begin
          // One digit per busy cycle, whatever is left at exit is the skipped count
          step <= step - durT'(1);
          if (lastStep || nextZero) begin
            state <= StDone;
          end
        end
        StDone: begin
          // Result stage back-pressure keeps the result on the outputs
          if (!holdResult) begin
            state <= StIdle;
          end
        end
        default: begin
          state <= StIdle;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  assign load       = accept;
  assign iterate    = (state == StBusy);
  assign busy       = (state == StBusy);
  assign done       = (state == StDone);
  assign earlyShift = step;

  // Final remainder resolved once, it is stable while done holds
  assign remainder = res.wS + res.wC;

  // Nonzero remainder means the truncated quotient lost bits
  assign sticky = |remainder;

  // Negative remainder means the digit sum overshot by one unit
  assign negRemainder = remainder[DivLen+3];

endmodule

// ==== srtIteration.sv ====
/*
  SRT residual datapath
  Carry-save residual and divisor registers
  Radix-2 quotient digit selection and 3:2 divisor-multiple adder
*/
`timescale 1ns/1ps

module srtIteration (
  input  logic clk,
  input  logic load,
  input  logic iterate,
  input  divPkg::sigT sigX,
  input  divPkg::sigT sigY,
  residualIf.datapath res,
  output logic digitPos,
  output logic digitNeg
);
  import divPkg::*;

  sigT divisor;
  residualT divExt;
  residualT wsShift;
  residualT wcShift;
  logic [3:0] estimate;
  residualT candSum;
  residualT candMaj;
  residualT candCarry;
  logic candZero;
  residualT addend;
  residualT majority;

  ////////////////////////////////////////////////////////////
  // Residual and divisor registers
  ////////////////////////////////////////////////////////////

  // Start loads W0 = X/2 with an empty carry word, so W0 < D holds
  // The divisor is captured once so the operand bus may change while busy
  always_ff @(posedge clk) begin
    if (load) begin
      divisor <= sigY;
      res.wS  <= {4'b0000, sigX};
      res.wC  <= '0;
    end else if (iterate) begin
      res.wS <= res.nextWS;
      res.wC <= res.nextWC;
    end
  end

  // Divisor in residual format, the leading one lands on the units bit
  assign divExt = {3'b000, divisor, 1'b0};

  // Both words doubled, the dropped top bit is only sign extension
  assign wsShift = {res.wS[DivLen+2:0], 1'b0};
  assign wcShift = {res.wC[DivLen+2:0], 1'b0};

  ////////////////////////////////////////////////////////////
  // Digit selection
  ////////////////////////////////////////////////////////////

  // Integer part of 2W from the top four bits of each word
  // The estimate sits at most two units below the true value
  assign estimate = wsShift[DivLen+3:DivLen] + wcShift[DivLen+3:DivLen];

  // Zero test of 2W + D on its own carry-save pair
  // This is the residual that digit -1 would produce
  assign candSum   = wsShift ^ wcShift ^ divExt;
  assign candMaj   = (wsShift & wcShift) | (wsShift & divExt) | (wcShift & divExt);
  assign candCarry = {candMaj[DivLen+2:0], 1'b0};
  assign candZero  = ((candSum ^ candCarry) ==
                      {candSum[DivLen+2:0] | candCarry[DivLen+2:0], 1'b0});

  // Estimate of zero or more gives +1, minus one gives 0, anything lower gives -1
  // With the smallest divisor a residual of exactly -D/2 would turn into -D
  // under digit 0, so -1 is taken there and the residual lands on zero
  always_comb begin
    digitPos = 1'b0;
    digitNeg = 1'b0;
    if (!estimate[3]) begin
      digitPos = 1'b1;
    end else if ((estimate != 4'b1111) || candZero) begin
      digitNeg = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Divisor-multiple addition
  ////////////////////////////////////////////////////////////

  // Digit +1 subtracts D as its complement plus one
  // The one rides in the free carry LSB
  always_comb begin
    if (digitPos) begin
      addend = ~divExt;
    end else if (digitNeg) begin
      addend = divExt;
    end else begin
      addend = '0;
    end
  end

  // 3:2 compressor, no carry ripples across the word
  assign majority   = (wsShift & wcShift) | (wsShift & addend) | (wcShift & addend);
  assign res.nextWS = wsShift ^ wcShift ^ addend;
  assign res.nextWC = {majority[DivLen+2:0], digitPos};

endmodule

// ==== quotientConverter.sv ====
/*
  On-the-fly conversion of signed SRT digits into the quotient
  Final correction for a negative remainder
  Left shift that restores digits skipped by early termination
*/
`timescale 1ns/1ps

module quotientConverter (
  input  logic clk,
  input  logic load,
  input  logic iterate,
  input  logic digitPos,
  input  logic digitNeg,
  input  logic negRemainder,
  input  divPkg::durT earlyShift,
  output divPkg::quotT quotient
);
  import divPkg::*;

  quotT q;
  quotT qm;
  quotT chosen;

  ////////////////////////////////////////////////////////////
  // Q and QM = Q - 1 kept side by side
  ////////////////////////////////////////////////////////////

  // Each digit only appends a bit to one of the two forms
  // so a negative digit never needs a borrow chain
  always_ff @(posedge clk) begin
    if (load) begin
      // Empty quotient, its partner is minus one in two's complement
      q  <= '0;
      qm <= '1;
    end else if (iterate) begin
      if (digitPos) begin
        // 2Q + 1, and 2Q for the partner
        q  <= {q[NumDigits-2:0], 1'b1};
        qm <= {q[NumDigits-2:0], 1'b0};
      end else if (digitNeg) begin
        // 2Q - 1 equals 2(Q-1) + 1
        q  <= {qm[NumDigits-2:0], 1'b1};
        qm <= {qm[NumDigits-2:0], 1'b0};
      end else begin
        q  <= {q[NumDigits-2:0], 1'b0};
        qm <= {qm[NumDigits-2:0], 1'b1};
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Result
  ////////////////////////////////////////////////////////////

  // A negative final remainder means the digits overshot by one
  assign chosen = negRemainder ? qm : q;

  // After an early exit every remaining digit is zero
  // shifting by the leftover step count fills them in
  assign quotient = chosen << earlyShift;

endmodule

// ==== srtDivider.sv ====
/*
  Radix-2 SRT significand divider, top level
  Controller, residual datapath and quotient converter
*/
`timescale 1ns/1ps

module srtDivider (
  input  logic clk,
  input  logic reset,
  input  logic start,
  input  logic holdStart,
  input  logic holdResult,
  input  logic xZero,
  input  logic yZero,
  input  logic xInf,
  input  logic yInf,
  input  logic xNaN,
  input  logic yNaN,
  input  logic [15:0] sigX,
  input  logic [15:0] sigY,
  output logic [16:0] quotient,
  output logic sticky,
  output logic busy,
  output logic done
);
  import divPkg::*;

  // Residual words shared by the datapath and the controller
  residualIf res ();

  // Control strobes from the FSM
  logic load;
  logic iterate;
  logic negRemainder;
  durT earlyShift;

  // Selected digit, one-hot between +1 and -1, both low for 0
  logic digitPos;
  logic digitNeg;

  srtController srtController_inst (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .holdStart    (holdStart),
    .holdResult   (holdResult),
    .xZero        (xZero),
    .yZero        (yZero),
    .xInf         (xInf),
    .yInf         (yInf),
    .xNaN         (xNaN),
    .yNaN         (yNaN),
    .res          (res.control),
    .load         (load),
    .iterate      (iterate),
    .earlyShift   (earlyShift),
    .negRemainder (negRemainder),
    .sticky       (sticky),
    .busy         (busy),
    .done         (done)
  );

  srtIteration srtIteration_inst (
    .clk      (clk),
    .load     (load),
    .iterate  (iterate),
    .sigX     (sigX),
    .sigY     (sigY),
    .res      (res.datapath),
    .digitPos (digitPos),
    .digitNeg (digitNeg)
  );

  quotientConverter quotientConverter_inst (
    .clk          (clk),
    .load         (load),
    .iterate      (iterate),
    .digitPos     (digitPos),
    .digitNeg     (digitNeg),
    .negRemainder (negRemainder),
    .earlyShift   (earlyShift),
    .quotient     (quotient)
  );

endmodule

// ==== srtDivider_chk.sv ====
/*
  Control timing checks bound to the divider top level
  Reset state, start acceptance, busy length, special operands, result hold
*/
`timescale 1ns/1ps

module srtDivider_chk (
  input logic clk,
  input logic reset,
  input logic start,
  input logic holdStart,
  input logic holdResult,
  input logic xZero, yZero, xInf, yInf, xNaN, yNaN,
  input logic [16:0] quotient,
  input logic sticky,
  input logic busy,
  input logic done
);

  // Read by the testbench summary
  int failCount = 0;
  logic special;
  logic idle;
  logic [4:0] busyRun;

  assign special = xZero | yZero | xInf | yInf | xNaN | yNaN;
  assign idle = !busy && !done;

  // Busy cycles in a row before the current edge, saturating
  always_ff @(posedge clk) begin
    if (reset || !busy) begin
      busyRun <= '0;
    end else if (busyRun != 5'd31) begin
      busyRun <= busyRun + 5'd1;
    end
  end

  task automatic countFailure(input string what);
    failCount++;
    $error("%s", what);
  endtask

  ////////////////////////////////////////////////////////////
  // Control timing
  ////////////////////////////////////////////////////////////

  // A reset edge always leaves the unit idle
  assert property (@(posedge clk) reset |=> idle)
    else countFailure("busy or done high after reset");

  assert property (@(posedge clk) disable iff (reset) !(busy && done))
    else countFailure("busy and done high together");

  // Accepted start with normal operands iterates from the next edge
  assert property (@(posedge clk) disable iff (reset)
    (start && !holdStart && idle && !special) |=> busy)
    else countFailure("accepted start did not raise busy");

  // Special operands skip the iteration
  assert property (@(posedge clk) disable iff (reset)
    (start && !holdStart && idle && special) |=> (done && !busy))
    else countFailure("special operand start did not go straight to done");

  assert property (@(posedge clk) disable iff (reset)
    (start && holdStart && idle) |=> idle)
    else countFailure("start accepted while holdStart was high");

  // At most one busy cycle per quotient digit
  assert property (@(posedge clk) disable iff (reset) busy |-> (busyRun < 5'd17))
    else countFailure("busy lasted more than 17 cycles");

  assert property (@(posedge clk) disable iff (reset)
    (done && holdResult) |=> (done && $stable(quotient) && $stable(sticky)))
    else countFailure("result not held while holdResult was high");

  assert property (@(posedge clk) disable iff (reset) (done && !holdResult) |=> idle)
    else countFailure("unit not idle one edge after the result was released");

endmodule

// ==== tbSrtDivider.sv ====
/*
  Testbench for the SRT significand divider
  Clock, reset, LFSR operands and a reference quotient model
  Directed corner, exact, special, hold and control cases
  Watchdog and closing error summary
*/
`timescale 1ns/1ps

module tbSrtDivider;

  localparam int ClkPeriod = 40;
  localparam int NumRandom = 200;
  // Random operations plus the directed ones, with room to spare
  localparam int NumOps = NumRandom + 30;
  localparam int DoneLimit = 40;
  localparam int MaxBusy = 17;
  localparam logic [31:0] LfsrSeed = 32'h1f8a_1bb9;
  localparam logic [31:0] LfsrTaps = 32'h8020_0003;

  logic clk;
  logic reset;
  logic start;
  logic holdStart;
  logic holdResult;
  logic xZero, yZero, xInf, yInf, xNaN, yNaN;
  logic [15:0] sigX;
  logic [15:0] sigY;
  logic [16:0] quotient;
  logic sticky;
  logic busy;
  logic done;

  logic [31:0] lfsr;
  int resultErrors;
  int controlErrors;
  int busyCycles;
  int latency;
  logic [15:0] opX;
  logic [15:0] opY;
  logic [16:0] heldQuotient;
  logic heldSticky;

  srtDivider srtDivider_inst (.*);

  // Control timing checks sit beside the DUT
  bind srtDivider srtDivider_chk timingChecks (.*);

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // About 25 cycles per operation covers the longest divide and the hold test
  initial begin
    #(ClkPeriod * (NumOps * 25 + 20));
    $display("Watchdog expired before the tests finished, the divider seems to hang");
    $display("TB FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    lfsrNext = s[0] ? ((s >> 1) ^ LfsrTaps) : (s >> 1);
  endfunction

  // Fifteen random bits under a forced leading one
  task automatic drawSignificand(output logic [15:0] sig);
    sig = 16'h0000;
    for (int i = 0; i < 15; i++) begin
      sig = {sig[14:0], lfsr[0]};
      lfsr = lfsrNext(lfsr);
    end
    sig[15] = 1'b1;
  endtask

  // Called 2 ns after an edge with the DUT idle, returns 2 ns after the accepting edge
  task automatic issueStart(input logic [15:0] x, input logic [15:0] y, input logic [5:0] flags);
    sigX = x;
    sigY = y;
    {xZero, yZero, xInf, yInf, xNaN, yNaN} = flags;
    start = 1'b1;
    @(posedge clk);
    #2;
    start = 1'b0;
    {xZero, yZero, xInf, yInf, xNaN, yNaN} = 6'b000000;
  endtask

  // Latency counts edges from acceptance to the first done cycle
  task automatic awaitDone();
    busyCycles = 0;
    latency = 1;
    while (!done && latency <= DoneLimit) begin
      if (busy) begin
        busyCycles++;
      end
      @(posedge clk);
      #2;
      latency++;
    end
    if (!done) begin
      $display("Divider did not raise done within %0d cycles of a start", DoneLimit);
      controlErrors++;
    end
  endtask

  // Reference is the truncated X * 2^16 / Y and its remainder
  task automatic checkResult(input logic [15:0] x, input logic [15:0] y);
    logic [31:0] dividend;
    logic [31:0] divisor;
    logic [31:0] expQuotient;
    logic expSticky;
    dividend = {x, 16'h0000};
    divisor = {16'h0000, y};
    expQuotient = dividend / divisor;
    expSticky = (dividend % divisor) != 32'd0;
    assert (quotient == expQuotient[16:0]) else begin
      $display("Error: time %0t quotient expected %05h actual %05h",
               $time, expQuotient[16:0], quotient);
      resultErrors++;
    end
    assert (sticky == expSticky) else begin
      $display("Error: time %0t sticky expected %0b actual %0b", $time, expSticky, sticky);
      resultErrors++;
    end
  endtask

  // With holdResult low the done cycle ends on the next edge
  task automatic finishOp();
    @(posedge clk);
    #2;
    assert (!busy && !done) else begin
      $display("Divider did not return to idle one edge after the result was released");
      controlErrors++;
    end
  endtask

  task automatic divideAndCheck(input logic [15:0] x, input logic [15:0] y);
    issueStart(x, y, 6'b000000);
    awaitDone();
    checkResult(x, y);
    finishOp();
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    reset = 1'b1;
    start = 1'b0;
    holdStart = 1'b0;
    holdResult = 1'b0;
    {xZero, yZero, xInf, yInf, xNaN, yNaN} = 6'b000000;
    sigX = 16'h8000;
    sigY = 16'h8000;
    lfsr = LfsrSeed;
    resultErrors = 0;
    controlErrors = 0;
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;
    assert (!busy && !done) else begin
      $display("Busy or done is high right after reset");
      controlErrors++;
    end

    // Largest over smallest, smallest over largest, then exact quotients
    divideAndCheck(16'hFFFF, 16'h8000);
    divideAndCheck(16'h8000, 16'hFFFF);
    divideAndCheck(16'hC000, 16'h8000);
    divideAndCheck(16'h8000, 16'h8000);
    for (int i = 0; i < 4; i++) begin
      drawSignificand(opX);
      divideAndCheck(opX, opX);
      // Equal operands leave a zero residual after the first digit
      assert (busyCycles < MaxBusy) else begin
        $display("Equal operands ran %0d busy cycles without early termination", busyCycles);
        controlErrors++;
      end
    end

    for (int i = 0; i < NumRandom; i++) begin
      drawSignificand(opX);
      drawSignificand(opY);
      divideAndCheck(opX, opY);
    end

    // One special flag at a time finishes on the next edge without busy
    for (int i = 0; i < 6; i++) begin
      drawSignificand(opX);
      drawSignificand(opY);
      issueStart(opX, opY, 6'b000001 << i);
      awaitDone();
      assert (latency == 1 && busyCycles == 0) else begin
        $display("Special operand took %0d edges and %0d busy cycles", latency, busyCycles);
        controlErrors++;
      end
      finishOp();
    end

    // Start under holdStart must not be taken
    start = 1'b1;
    holdStart = 1'b1;
    @(posedge clk);
    #2;
    start = 1'b0;
    holdStart = 1'b0;
    assert (!busy && !done) else begin
      $display("Start was accepted although holdStart was high");
      controlErrors++;
    end

    // A second start and new operands while busy leave the running divide alone
    issueStart(16'hB3C5, 16'h9A17, 6'b000000);
    sigX = 16'hFFFF;
    sigY = 16'h8001;
    start = 1'b1;
    @(posedge clk);
    #2;
    start = 1'b0;
    awaitDone();
    checkResult(16'hB3C5, 16'h9A17);
    finishOp();

    // Result stays put while the result stage holds it, starts are ignored
    holdResult = 1'b1;
    issueStart(16'hD00D, 16'h8421, 6'b000000);
    awaitDone();
    checkResult(16'hD00D, 16'h8421);
    heldQuotient = quotient;
    heldSticky = sticky;
    repeat (6) begin
      start = 1'b1;
      @(posedge clk);
      #2;
      assert (done && quotient == heldQuotient && sticky == heldSticky) else begin
        $display("Done dropped or the result changed while holdResult was high");
        controlErrors++;
      end
    end
    start = 1'b0;
    holdResult = 1'b0;
    finishOp();

    $display("Summary: %0d result errors, %0d control errors, %0d timing check failures",
             resultErrors, controlErrors, srtDivider_inst.timingChecks.failCount);
    if (resultErrors + controlErrors + srtDivider_inst.timingChecks.failCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
divPkg.sv
residualIf.sv
srtController.sv
srtIteration.sv
quotientConverter.sv
srtDivider.sv
srtDivider_chk.sv
tbSrtDivider.sv

// ==== Makefile ====
# Verilator build and run of the SRT divider testbench

SIM = obj_dir/VtbSrtDivider

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and pass only if the testbench passes"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -f build.f --top-module tbSrtDivider -Mdir obj_dir
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir
